/* bench/blackjack_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module blackjack_sva import blackjack_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        draw,
    input logic        start_round,
    input logic        settle,
    input outcome_t    outcome,
    input game_phase_t phase,
    input coin_t       coins
);

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    draw_in_card_phase: assert property (@(posedge clk) disable iff (reset)
        draw |-> (phase == PHASE_DEALING || phase == PHASE_PLAYER || phase == PHASE_DEALER))
        else $error("draw strobe outside the dealing, player or dealer phase");

    no_outcome_while_dealing: assert property (@(posedge clk) disable iff (reset)
        (phase == PHASE_DEALING) |-> (outcome == OUTCOME_NONE))
        else $error("outcome set while cards are dealt");

    // ------------------------------------------------------------
    // bank
    // ------------------------------------------------------------
    coins_change_on_strobe: assert property (@(posedge clk) disable iff (reset)
        (!$past(start_round) && !$past(settle)) |-> (coins == $past(coins)))
        else $error("coins changed without start_round or settle");

endmodule

bind blackjack_top blackjack_sva blackjack_sva_i (
    .clk        (clk),
    .reset      (reset),
    .draw       (draw),
    .start_round(start_round),
    .settle     (settle),
    .outcome    (outcome),
    .phase      (phase),
    .coins      (coins)
);

`default_nettype wire

/* bench/blackjack_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module blackjack_tb import blackjack_pkg::*; ();

    localparam int CLK_PERIOD       = 100;
    localparam int ROUND_TIMEOUT    = 40;
    localparam int MAX_BUST_TRIES   = 8;
    localparam int SEQ_ROUNDS       = 10;
    localparam int MAX_DRAIN_ROUNDS = 40;
    localparam int ROUND_COUNT      = 3 + MAX_BUST_TRIES + SEQ_ROUNDS + MAX_DRAIN_ROUNDS;
    localparam int WATCHDOG_CYCLES  = ROUND_COUNT * 60 + 8;

    logic        clk;
    logic        reset;
    logic        next;
    logic        hit;
    logic        stand;
    bet_t        bet;
    score_t      player_score;
    score_t      dealer_score;
    coin_t       coins;
    outcome_t    outcome;
    game_phase_t phase;

    logic [15:0] deck_state;
    logic [31:0] rand_state;
    int          exp_coins;
    int          error_count;
    int          test_count;

    blackjack_top blackjack_top_i (
        .clk         (clk),
        .reset       (reset),
        .next        (next),
        .hit         (hit),
        .stand       (stand),
        .bet         (bet),
        .player_score(player_score),
        .dealer_score(dealer_score),
        .coins       (coins),
        .outcome     (outcome),
        .phase       (phase)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic card_t draw_card();
        int   rank;
        logic fb;
        rank = int'(deck_state % 16'd13) + 1;
        fb = deck_state[15] ^ deck_state[13] ^ deck_state[12] ^ deck_state[10];
        deck_state = {deck_state[14:0], fb};
        if (rank > 10) begin
            rank = 10;
        end
        return card_t'(rank);
    endfunction

    function automatic logic random_bit();
        logic fb;
        fb = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
        rand_state = {rand_state[30:0], fb};
        return fb;
    endfunction

    function automatic bet_t random_bet();
        bet_t b;
        b = '0;
        for (int i = 0; i < 4; i++) begin
            b = {b[2:0], random_bit()};
        end
        return b;
    endfunction

    task automatic add_card(inout int hard, inout logic ace, input card_t c);
        hard = hard + int'(c);
        if (c == 4'd1) begin
            ace = 1'b1;
        end
    endtask

    // one ace counts high if that keeps the hand at 21 or below
    function automatic int hand_score(int hard, logic ace);
        if (ace && (hard + int'(ACE_BONUS) <= int'(BLACKJACK))) begin
            return hard + int'(ACE_BONUS);
        end
        return hard;
    endfunction

    function automatic outcome_t judge(int p, int d);
        if (p > int'(BLACKJACK)) begin
            return OUTCOME_LOSE;
        end else if (d > int'(BLACKJACK) || p > d) begin
            return OUTCOME_WIN;
        end else if (p < d) begin
            return OUTCOME_LOSE;
        end
        return OUTCOME_DRAW;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_score(input string name, input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_coins(input coin_t got, input coin_t exp);
        if (got !== exp) begin
            $display("error coins: got %h, expected %h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_outcome(input outcome_t got, input outcome_t exp);
        if (got !== exp) begin
            $display("error outcome: got %h, expected %h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_phase(input game_phase_t got, input game_phase_t exp);
        if (got !== exp) begin
            $display("error phase: got %h, expected %h", got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failures", name, error_count - start_errors);
        end
    endtask

    // ------------------------------------------------------------
    // round drivers
    // ------------------------------------------------------------
    task automatic try_rejected(input bet_t b);
        bet  = b;
        next = 1'b1;
        @(negedge clk);
        next = 1'b0;
        check_phase(phase, PHASE_BETTING);
        @(negedge clk);
        check_phase(phase, PHASE_BETTING);
        check_coins(coins, coin_t'(exp_coins));
    endtask

    // player hits while below hit_below and below 21
    task automatic play_round(input bet_t b, input int hit_below, output logic busted);
        int       p_hard;
        int       d_hard;
        logic     p_ace;
        logic     d_ace;
        int       p_sc;
        int       d_sc;
        int       waited;
        int       payout;
        outcome_t exp_out;
        p_hard = 0;
        d_hard = 0;
        p_ace  = 1'b0;
        d_ace  = 1'b0;
        bet    = b;
        next   = 1'b1;
        @(negedge clk);
        next = 1'b0;
        exp_coins = exp_coins - int'(b);
        check_phase(phase, PHASE_DEALING);
        repeat (4) @(negedge clk);
        check_phase(phase, PHASE_PLAYER);

        // deal order player, dealer, player, dealer
        for (int i = 0; i < 4; i++) begin
            if (i % 2 == 0) begin
                add_card(p_hard, p_ace, draw_card());
            end else begin
                add_card(d_hard, d_ace, draw_card());
            end
        end
        p_sc = hand_score(p_hard, p_ace);
        d_sc = hand_score(d_hard, d_ace);
        check_score("player_score", player_score, score_t'(p_sc));
        check_score("dealer_score", dealer_score, score_t'(d_sc));
        check_coins(coins, coin_t'(exp_coins));

        while (p_sc < int'(BLACKJACK) && p_sc < hit_below) begin
            hit = 1'b1;
            @(negedge clk);
            hit = 1'b0;
            @(negedge clk);
            add_card(p_hard, p_ace, draw_card());
            p_sc = hand_score(p_hard, p_ace);
            check_score("player_score", player_score, score_t'(p_sc));
        end
        if (p_sc < int'(BLACKJACK)) begin
            stand = 1'b1;
            @(negedge clk);
            stand = 1'b0;
        end

        // dealer only plays when the player is still in
        if (p_sc <= int'(BLACKJACK)) begin
            while (d_sc < int'(DEALER_STAND)) begin
                add_card(d_hard, d_ace, draw_card());
                d_sc = hand_score(d_hard, d_ace);
            end
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (phase != PHASE_BETTING && waited < ROUND_TIMEOUT);
        if (phase != PHASE_BETTING) begin
            $display("round did not return to betting within %0d cycles", ROUND_TIMEOUT);
            error_count++;
        end

        exp_out = judge(p_sc, d_sc);
        payout  = 0;
        if (exp_out == OUTCOME_WIN) begin
            payout = (p_sc == int'(BLACKJACK)) ? 4 * int'(b) : 2 * int'(b);
        end else if (exp_out == OUTCOME_DRAW) begin
            payout = int'(b);
        end
        exp_coins = exp_coins + payout;
        if (exp_coins > int'(MAX_COINS)) begin
            exp_coins = int'(MAX_COINS);
        end
        check_outcome(outcome, exp_out);
        check_score("player_score", player_score, score_t'(p_sc));
        check_score("dealer_score", dealer_score, score_t'(d_sc));
        check_coins(coins, coin_t'(exp_coins));
        busted = (p_sc > int'(BLACKJACK));
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int start_errors;
        start_errors = error_count;
        check_phase(phase, PHASE_BETTING);
        check_coins(coins, coin_t'(exp_coins));
        check_outcome(outcome, OUTCOME_NONE);
        check_score("player_score", player_score, '0);
        check_score("dealer_score", dealer_score, '0);
        report_test("reset state", start_errors);
    endtask

    task automatic test_zero_bet();
        int start_errors;
        start_errors = error_count;
        try_rejected(4'd0);
        report_test("zero bet", start_errors);
    endtask

    task automatic test_dealing();
        int   start_errors;
        logic busted;
        start_errors = error_count;
        play_round(4'd5, 12, busted);
        report_test("dealing", start_errors);
    endtask

    task automatic test_player_bust();
        int   start_errors;
        int   tries;
        logic busted;
        start_errors = error_count;
        tries = 0;
        do begin
            play_round(4'd3, 22, busted);
            tries++;
        end while (!busted && tries < MAX_BUST_TRIES);
        if (!busted) begin
            $display("player never went over 21 in %0d rounds", tries);
            error_count++;
        end
        report_test("player hits and busts", start_errors);
    endtask

    task automatic test_stand();
        int   start_errors;
        logic busted;
        start_errors = error_count;
        play_round(4'd9, 0, busted);
        report_test("stand and dealer turn", start_errors);
    endtask

    task automatic test_sequence();
        int   start_errors;
        bet_t b;
        logic busted;
        start_errors = error_count;
        for (int r = 0; r < SEQ_ROUNDS; r++) begin
            b = random_bet();
            if (b == 4'd0 || int'(b) > exp_coins) begin
                try_rejected(b);
            end else begin
                play_round(b, 15, busted);
            end
        end
        report_test("round sequence", start_errors);
    endtask

    // lose coins until a bet above the balance is possible
    task automatic test_over_balance();
        int   start_errors;
        int   rounds;
        logic busted;
        start_errors = error_count;
        rounds = 0;
        while (exp_coins >= 15 && rounds < MAX_DRAIN_ROUNDS) begin
            play_round(4'd15, 22, busted);
            rounds++;
        end
        if (exp_coins < 15) begin
            try_rejected(bet_t'(exp_coins + 1));
        end else begin
            $display("balance stayed at 15 or more, bet above balance not tried");
            error_count++;
        end
        report_test("bet above balance", start_errors);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        next        = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        bet         = '0;
        deck_state  = 16'hace1;
        rand_state  = 32'h8d06b9da;
        exp_coins   = 100;
        error_count = 0;
        test_count  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_reset();
        test_zero_bet();
        test_dealing();
        test_player_bust();
        test_stand();
        test_sequence();
        test_over_balance();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/blackjack_pkg.sv
src/card_deck.sv
src/hand_scorer.sv
src/game_control.sv
src/coin_bank.sv
src/blackjack_top.sv
bench/blackjack_sva.sv
bench/blackjack_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module blackjack_tb -f build.f

# grep fails the script unless the pass line was printed
./obj_dir/Vblackjack_tb 2>&1 | tee /dev/stderr | grep "^No errors$" > /dev/null
echo "simulation passed"

/* src/blackjack_pkg.sv */
`default_nettype none

package blackjack_pkg;

    // card value 1..10, ace is 1
    typedef logic [3:0] card_t;

    // hand score, hard sum can pass 21
    typedef logic [5:0] score_t;

    typedef logic [7:0] coin_t;
    typedef logic [3:0] bet_t;

    typedef enum logic [2:0] {
        PHASE_BETTING = 3'd0,
        PHASE_DEALING = 3'd1,
        PHASE_PLAYER  = 3'd2,
        PHASE_DEALER  = 3'd3,
        PHASE_SETTLE  = 3'd4
    } game_phase_t;

    typedef enum logic [1:0] {
        OUTCOME_NONE = 2'd0,
        OUTCOME_WIN  = 2'd1,
        OUTCOME_LOSE = 2'd2,
        OUTCOME_DRAW = 2'd3
    } outcome_t;

    // ------------------------------------------------------------
    // rule constants
    // ------------------------------------------------------------
    localparam score_t BLACKJACK    = 6'd21;
    localparam score_t DEALER_STAND = 6'd17;
    localparam score_t ACE_BONUS    = 6'd10;
    localparam coin_t  MAX_COINS    = 8'd255;

endpackage

`default_nettype wire

/* src/blackjack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module blackjack_top import blackjack_pkg::*; #(
    parameter coin_t       INITIAL_COINS = 8'd100,
    parameter logic [15:0] DECK_SEED     = 16'hace1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        next,
    input  logic        hit,
    input  logic        stand,
    input  bet_t        bet,
    output score_t      player_score,
    output score_t      dealer_score,
    output coin_t       coins,
    output outcome_t    outcome,
    output game_phase_t phase
);

    card_t card;
    logic  draw;
    logic  player_add;
    logic  dealer_add;
    logic  clear_hands;
    logic  start_round;
    logic  settle;
    logic  bet_ok;

    card_deck #(
        .DECK_SEED(DECK_SEED)
    ) card_deck_i (
        .clk  (clk),
        .reset(reset),
        .draw (draw),
        .card (card)
    );

    // ------------------------------------------------------------
    // hands
    // ------------------------------------------------------------
    hand_scorer player_scorer_i (
        .clk  (clk),
        .reset(reset),
        .clear(clear_hands),
        .add  (player_add),
        .card (card),
        .score(player_score)
    );

    hand_scorer dealer_scorer_i (
        .clk  (clk),
        .reset(reset),
        .clear(clear_hands),
        .add  (dealer_add),
        .card (card),
        .score(dealer_score)
    );

    game_control game_control_i (
        .clk         (clk),
        .reset       (reset),
        .next        (next),
        .hit         (hit),
        .stand       (stand),
        .bet_ok      (bet_ok),
        .player_score(player_score),
        .dealer_score(dealer_score),
        .draw        (draw),
        .player_add  (player_add),
        .dealer_add  (dealer_add),
        .clear_hands (clear_hands),
        .start_round (start_round),
        .settle      (settle),
        .outcome     (outcome),
        .phase       (phase)
    );

    coin_bank #(
        .INITIAL_COINS(INITIAL_COINS)
    ) coin_bank_i (
        .clk         (clk),
        .reset       (reset),
        .bet         (bet),
        .start_round (start_round),
        .settle      (settle),
        .outcome     (outcome),
        .player_score(player_score),
        .bet_ok      (bet_ok),
        .coins       (coins)
    );

endmodule

`default_nettype wire

/* src/card_deck.sv */
`timescale 1ns/1ps
`default_nettype none

module card_deck import blackjack_pkg::*; #(
    parameter logic [15:0] DECK_SEED = 16'hace1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  draw,
    output card_t card
);

    logic [15:0] lfsr;
    logic        feedback;
    card_t       card_raw;

    // taps 16, 14, 13, 11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= DECK_SEED;
        end else if (draw) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    // rank 1..13, face cards count as 10
    always_comb begin
        card_raw = card_t'(lfsr % 16'd13) + 4'd1;
        if (card_raw > 4'd10) begin
            card = 4'd10;
        end else begin
            card = card_raw;
        end
    end

endmodule

`default_nettype wire

/* src/coin_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module coin_bank import blackjack_pkg::*; #(
    parameter coin_t INITIAL_COINS = 8'd100
) (
    input  logic     clk,
    input  logic     reset,
    input  bet_t     bet,
    input  logic     start_round,
    input  logic     settle,
    input  outcome_t outcome,
    input  score_t   player_score,
    output logic     bet_ok,
    output coin_t    coins
);

    bet_t       bet_q;
    logic [8:0] payout;
    logic [8:0] total;

    assign bet_ok = (bet != '0) && (coin_t'(bet) <= coins);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bet_q <= '0;
        end else if (start_round) begin
            bet_q <= bet;
        end
    end

    // ------------------------------------------------------------
    // payout
    // ------------------------------------------------------------
    always_comb begin
        case (outcome)
            OUTCOME_WIN: begin
                if (player_score == BLACKJACK) begin
                    payout = {3'd0, bet_q, 2'd0};
                end else begin
                    payout = {4'd0, bet_q, 1'b0};
                end
            end
            OUTCOME_DRAW: payout = {5'd0, bet_q};
            default:      payout = 9'd0;
        endcase
        total = {1'b0, coins} + payout;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins <= INITIAL_COINS;
        end else if (start_round) begin
            coins <= coins - coin_t'(bet);
        end else if (settle) begin
            // saturate at the top of the range
            if (total > {1'b0, MAX_COINS}) begin
                coins <= MAX_COINS;
            end else begin
                coins <= total[7:0];
            end
        end
    end

endmodule

`default_nettype wire

/* src/game_control.sv */
`timescale 1ns/1ps
`default_nettype none

module game_control import blackjack_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        next,
    input  logic        hit,
    input  logic        stand,
    input  logic        bet_ok,
    input  score_t      player_score,
    input  score_t      dealer_score,
    output logic        draw,
    output logic        player_add,
    output logic        dealer_add,
    output logic        clear_hands,
    output logic        start_round,
    output logic        settle,
    output outcome_t    outcome,
    output game_phase_t phase
);

    logic [1:0] deal_cnt;
    logic       pending;
    logic       accept;
    logic       deal_draw;
    logic       player_draw;
    logic       dealer_draw;
    logic       turn_over;
    outcome_t   outcome_q;
    outcome_t   judged;

    // ------------------------------------------------------------
    // strobes
    // ------------------------------------------------------------
    assign accept = (phase == PHASE_BETTING) && next && bet_ok;

    // natural 21 or bust also ends the turn
    assign turn_over = stand || (player_score >= BLACKJACK);

    assign deal_draw   = (phase == PHASE_DEALING);
    assign player_draw = (phase == PHASE_PLAYER) && !pending && !turn_over && hit;
    assign dealer_draw = (phase == PHASE_DEALER) && !pending && (dealer_score < DEALER_STAND);

    assign draw        = deal_draw || player_draw || dealer_draw;
    // deal order is player, dealer, player, dealer
    assign player_add  = (deal_draw && !deal_cnt[0]) || player_draw;
    assign dealer_add  = (deal_draw && deal_cnt[0]) || dealer_draw;
    assign clear_hands = accept;
    assign start_round = accept;
    assign settle      = (phase == PHASE_SETTLE);

    // ------------------------------------------------------------
    // judgement
    // ------------------------------------------------------------
    always_comb begin
        if (player_score > BLACKJACK) begin
            judged = OUTCOME_LOSE;
        end else if (dealer_score > BLACKJACK) begin
            judged = OUTCOME_WIN;
        end else if (player_score > dealer_score) begin
            judged = OUTCOME_WIN;
        end else if (player_score < dealer_score) begin
            judged = OUTCOME_LOSE;
        end else begin
            judged = OUTCOME_DRAW;
        end
    end

    // bank needs the result during the settle cycle itself
    assign outcome = settle ? judged : outcome_q;

    // ------------------------------------------------------------
    // round FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= PHASE_BETTING;
            deal_cnt  <= 2'd0;
            pending   <= 1'b0;
            outcome_q <= OUTCOME_NONE;
        end else begin
            case (phase)
                PHASE_BETTING: begin
                    if (accept) begin
                        phase     <= PHASE_DEALING;
                        deal_cnt  <= 2'd0;
                        outcome_q <= OUTCOME_NONE;
                    end
                end
                PHASE_DEALING: begin
                    deal_cnt <= deal_cnt + 2'd1;
                    if (deal_cnt == 2'd3) begin
                        phase <= PHASE_PLAYER;
                    end
                end
                PHASE_PLAYER: begin
                    // wait one cycle after a hit for the new score
                    if (pending) begin
                        pending <= 1'b0;
                    end else if (player_score > BLACKJACK) begin
                        phase <= PHASE_SETTLE;
                    end else if (turn_over) begin
                        phase <= PHASE_DEALER;
                    end else if (hit) begin
                        pending <= 1'b1;
                    end
                end
                PHASE_DEALER: begin
                    if (pending) begin
                        pending <= 1'b0;
                    end else if (dealer_draw) begin
                        pending <= 1'b1;
                    end else begin
                        phase <= PHASE_SETTLE;
                    end
                end
                PHASE_SETTLE: begin
                    outcome_q <= judged;
                    phase     <= PHASE_BETTING;
                end
                default: begin
                    phase <= PHASE_BETTING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/hand_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

module hand_scorer import blackjack_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   clear,
    input  logic   add,
    input  card_t  card,
    output score_t score
);

    score_t hard_sum;
    score_t soft_sum;
    logic   ace_seen;

    // ------------------------------------------------------------
    // hand accumulation
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hard_sum <= '0;
            ace_seen <= 1'b0;
        end else if (clear) begin
            hard_sum <= '0;
            ace_seen <= 1'b0;
        end else if (add) begin
            hard_sum <= hard_sum + score_t'(card);
            if (card == 4'd1) begin
                ace_seen <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // ace adjustment
    // ------------------------------------------------------------

    // only one ace can ever count high without busting
    assign soft_sum = hard_sum + ACE_BONUS;

    always_comb begin
        if (ace_seen && (soft_sum <= BLACKJACK)) begin
            score = soft_sum;
        end else begin
            score = hard_sum;
        end
    end

endmodule

`default_nettype wire
